// File: source/MemoryTypes.sv
package MemoryTypes;

// Step of a data access, driven by the sequencer
typedef enum logic [1:0]
{
	NOP,           // No access, flags held low
	LOAD,          // Registered read of the addressed word
	STORE_PRELOAD, // Read old word ahead of the merge
	STORE          // Write merged word at the end of the cycle
} MemoryMode;

// Request kind at the controller port
typedef enum logic
{
	OP_LOAD,
	OP_STORE
} MemoryOp;

// RV32I load/store funct3 codes
localparam logic [2:0] F3_BYTE = 3'b000;   // lb / sb
localparam logic [2:0] F3_HALF = 3'b001;   // lh / sh
localparam logic [2:0] F3_WORD = 3'b010;   // lw / sw
localparam logic [2:0] F3_BYTE_U = 3'b100; // lbu
localparam logic [2:0] F3_HALF_U = 3'b101; // lhu

// Start of the memory-mapped port window
// Eight words, port n at PORT_BASE + 4n
localparam logic [31:0] PORT_BASE = 32'hFFFFFFE0;

endpackage : MemoryTypes

// File: source/MemoryAccessSequencer.sv
`timescale 1ns/10ps

module MemoryAccessSequencer
(
	input clock,
	input rstN,

	// Request, sampled on start while idle
	input start,
	input MemoryTypes::MemoryOp op,
	input [2:0] funct3,
	input [31:0] rs1,
	input [31:0] immediate,
	input [31:0] rs2,

	input fault, // From the fault detector

	output MemoryTypes::MemoryMode memoryMode,
	output logic [29:0] wordAddress,
	output logic [1:0] offset,
	output logic [2:0] reqFunct3,
	output logic [31:0] reqData,
	output logic writeEnable, // Only write strobe in the design
	output logic busy,
	output logic done
);

typedef enum logic [1:0] {IDLE, ACCESS, FINISH} SeqState;

SeqState state, nextState;
MemoryTypes::MemoryOp reqOp;     // Latched request kind
logic [31:0] effectiveAddress; // rs1 + immediate

always_comb
begin
	unique case (state)
		IDLE: nextState = start ? ACCESS : IDLE; // start ignored once busy
		ACCESS: nextState = FINISH;
		FINISH: nextState = IDLE;
		default: nextState = IDLE;
	endcase
end

always_ff @(posedge clock)
begin
	if (!rstN)
		state <= IDLE;
	else
		state <= nextState;
end

// Request latch
always_ff @(posedge clock)
begin
	if (state == IDLE && start)
	begin
		reqOp <= op;
		reqFunct3 <= funct3;
		effectiveAddress <= rs1 + immediate;
		reqData <= rs2;
	end
end

// ACCESS reads the word, FINISH writes it back for stores
// Loads stay in LOAD through FINISH so the flags cover the done cycle
always_comb
begin
	unique case (state)
		ACCESS: memoryMode = (reqOp == MemoryTypes::OP_STORE) ?
			MemoryTypes::STORE_PRELOAD : MemoryTypes::LOAD;
		FINISH: memoryMode = (reqOp == MemoryTypes::OP_STORE) ?
			MemoryTypes::STORE : MemoryTypes::LOAD;
		default: memoryMode = MemoryTypes::NOP;
	endcase
end

assign wordAddress = effectiveAddress[31:2];
assign offset = effectiveAddress[1:0]; // Byte within the word

assign writeEnable = (memoryMode == MemoryTypes::STORE) && !fault; // Faulting store dropped
assign busy = state != IDLE;
assign done = state == FINISH;

endmodule : MemoryAccessSequencer

// File: source/MemoryFaultDetector.sv
`timescale 1ns/10ps

module MemoryFaultDetector
(
	input MemoryTypes::MemoryMode memoryMode,
	input [2:0] funct3,
	input [1:0] offset,

	output logic unalignedAccess,
	output logic badFunct3,
	output logic fault // Either flag
);

// Alignment by access size
always_comb
begin
	if (memoryMode == MemoryTypes::NOP)
		unalignedAccess = 1'b0; // No access in flight
	else
	begin
		unique case (funct3)
			MemoryTypes::F3_HALF, MemoryTypes::F3_HALF_U: unalignedAccess = offset[0];
			MemoryTypes::F3_WORD: unalignedAccess = offset != 2'b00;
			default: unalignedAccess = 1'b0; // Bytes, or a bad code caught below
		endcase
	end
end

// Codes that have no instruction
always_comb
begin
	unique case (memoryMode)
		MemoryTypes::LOAD:
			badFunct3 = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
		MemoryTypes::STORE_PRELOAD, MemoryTypes::STORE:
			badFunct3 = !((funct3 == MemoryTypes::F3_BYTE) || (funct3 == MemoryTypes::F3_HALF)
				|| (funct3 == MemoryTypes::F3_WORD)); // sb, sh, sw only
		default: badFunct3 = 1'b0;
	endcase
end

assign fault = unalignedAccess || badFunct3;

endmodule : MemoryFaultDetector

// File: source/MemoryLoadFormatter.sv
`timescale 1ns/10ps

module MemoryLoadFormatter
(
	input [2:0] funct3,
	input [1:0] offset,
	input [31:0] readWord,

	output logic [31:0] loadData // Value for rd
);

logic [7:0] byteLane;
logic [15:0] halfLane;

// Little-endian byte pick
always_comb
begin
	unique case (offset)
		2'b00: byteLane = readWord[7:0];
		2'b01: byteLane = readWord[15:8];
		2'b10: byteLane = readWord[23:16];
		2'b11: byteLane = readWord[31:24];
	endcase
end

// Halfword by offset bit 1
// A misaligned offset has already raised the fault flag
always_comb
begin
	if (offset[1])
		halfLane = readWord[31:16];
	else
		halfLane = readWord[15:0];
end

// Extension by funct3
always_comb
begin
	unique case (funct3)
		MemoryTypes::F3_BYTE: loadData = {{24{byteLane[7]}}, byteLane};  // lb
		MemoryTypes::F3_HALF: loadData = {{16{halfLane[15]}}, halfLane}; // lh
		MemoryTypes::F3_BYTE_U: loadData = {24'h000000, byteLane};        // lbu
		MemoryTypes::F3_HALF_U: loadData = {16'h0000, halfLane};          // lhu
		default: loadData = readWord; // lw, bad codes fall through here too
	endcase
end

endmodule : MemoryLoadFormatter

// File: source/MemoryStoreMerger.sv
`timescale 1ns/10ps

module MemoryStoreMerger
(
	input [2:0] funct3,
	input [1:0] offset,
	input [31:0] readWord,  // Old word from the preload cycle
	input [31:0] storeData, // rs2

	output logic [31:0] writeWord
);

logic [31:0] byteMerged;
logic [31:0] halfMerged;

// Byte lane replaced, rest of the old word kept
always_comb
begin
	byteMerged = readWord;
	unique case (offset)
		2'b00: byteMerged[7:0] = storeData[7:0];
		2'b01: byteMerged[15:8] = storeData[7:0];
		2'b10: byteMerged[23:16] = storeData[7:0];
		2'b11: byteMerged[31:24] = storeData[7:0];
	endcase
end

// Halfword lane, low byte at the lower address
always_comb
begin
	halfMerged = readWord;
	if (offset[1])
		halfMerged[31:16] = storeData[15:0];
	else
		halfMerged[15:0] = storeData[15:0];
end

always_comb
begin
	unique case (funct3)
		MemoryTypes::F3_BYTE: writeWord = byteMerged; // sb
		MemoryTypes::F3_HALF: writeWord = halfMerged; // sh
		default: writeWord = storeData; // sw, bad codes never written
	endcase
end

endmodule : MemoryStoreMerger

// File: source/MemoryBackend.sv
`timescale 1ns/10ps

module MemoryBackend
#(
	parameter int ramAddrWidth = 12 // RAM depth as word-address bits
)
(
	input clock,
	input rstN,

	// Data port
	input MemoryTypes::MemoryMode memoryMode,
	input writeEnable,
	input [29:0] wordAddress,
	input [31:0] writeWord,
	output logic [31:0] readWord,

	// Fetch port, read only
	input [31:0] fetchAddress,
	output logic [31:0] instruction,

	// Port inputs, read at FFFFFFE0 + 4n
	input [31:0] portAInput,
	input [31:0] portBInput,
	input [31:0] portCInput,
	input [31:0] portDInput,
	input [31:0] portEInput,
	input [31:0] portFInput,
	input [31:0] portGInput,
	input [31:0] portHInput,

	// Port output registers, written at the same addresses
	output logic [31:0] portAOutput,
	output logic [31:0] portBOutput,
	output logic [31:0] portCOutput,
	output logic [31:0] portDOutput,
	output logic [31:0] portEOutput,
	output logic [31:0] portFOutput,
	output logic [31:0] portGOutput,
	output logic [31:0] portHOutput
);

logic [31:0] ram [2**ramAddrWidth];
logic [31:0] portRegs [8];
logic [31:0] portInputs [8];
logic [ramAddrWidth-1:0] ramIndex;
logic [ramAddrWidth-1:0] fetchIndex;
logic [2:0] portIndex;
logic isPort;
logic readEnable;

assign isPort = wordAddress[29:3] == MemoryTypes::PORT_BASE[31:5]; // Top eight words
assign portIndex = wordAddress[2:0];
assign ramIndex = wordAddress[ramAddrWidth-1:0]; // Upper bits alias
assign fetchIndex = fetchAddress[ramAddrWidth+1:2];
assign readEnable = (memoryMode == MemoryTypes::LOAD) || (memoryMode == MemoryTypes::STORE_PRELOAD);

assign portInputs = '{portAInput, portBInput, portCInput, portDInput,
	portEInput, portFInput, portGInput, portHInput};

// Data and fetch ports share the array
always_ff @(posedge clock)
begin
	if (readEnable)
		readWord <= isPort ? portInputs[portIndex] : ram[ramIndex];
	if (writeEnable && !isPort)
		ram[ramIndex] <= writeWord;
	instruction <= ram[fetchIndex]; // Old word on the write edge
end

always_ff @(posedge clock)
begin
	if (!rstN)
		portRegs <= '{default: 32'h00000000};
	else if (writeEnable && isPort)
		portRegs[portIndex] <= writeWord;
end

assign portAOutput = portRegs[0];
assign portBOutput = portRegs[1];
assign portCOutput = portRegs[2];
assign portDOutput = portRegs[3];
assign portEOutput = portRegs[4];
assign portFOutput = portRegs[5];
assign portGOutput = portRegs[6];
assign portHOutput = portRegs[7];

endmodule : MemoryBackend

// File: source/MemoryController.sv
`timescale 1ns/10ps

module MemoryController
#(
	parameter int ramAddrWidth = 12
)
(
	input clock,
	input rstN,

	// Request strobe and operands
	input start,
	input MemoryTypes::MemoryOp op,
	input [2:0] funct3,
	input [31:0] rs1,
	input [31:0] immediate,
	input [31:0] rs2,

	// Results, valid while done
	output logic [31:0] loadData,
	output logic busy,
	output logic done,
	output logic unalignedAccess,
	output logic badFunct3,

	// Instruction fetch
	input [31:0] fetchAddress,
	output logic [31:0] instruction,

	input [31:0] portAInput,
	input [31:0] portBInput,
	input [31:0] portCInput,
	input [31:0] portDInput,
	input [31:0] portEInput,
	input [31:0] portFInput,
	input [31:0] portGInput,
	input [31:0] portHInput,
	output logic [31:0] portAOutput,
	output logic [31:0] portBOutput,
	output logic [31:0] portCOutput,
	output logic [31:0] portDOutput,
	output logic [31:0] portEOutput,
	output logic [31:0] portFOutput,
	output logic [31:0] portGOutput,
	output logic [31:0] portHOutput
);

MemoryTypes::MemoryMode memoryMode;
logic [29:0] wordAddress;
logic [1:0] offset;
logic [2:0] reqFunct3;
logic [31:0] reqData;
logic [31:0] readWord;  // Registered backend read
logic [31:0] writeWord; // Merged store word
logic writeEnable;
logic fault;

MemoryAccessSequencer sequencer0
(
	.clock, .rstN, .start, .op, .funct3, .rs1, .immediate, .rs2, .fault,
	.memoryMode, .wordAddress, .offset, .reqFunct3, .reqData, .writeEnable,
	.busy, .done
);

MemoryFaultDetector faultDetector0
(
	.memoryMode, .funct3(reqFunct3), .offset, .unalignedAccess, .badFunct3, .fault
);

MemoryLoadFormatter loadFormatter0
(
	.funct3(reqFunct3), .offset, .readWord, .loadData
);

MemoryStoreMerger storeMerger0
(
	.funct3(reqFunct3), .offset, .readWord, .storeData(reqData), .writeWord
);

MemoryBackend #(.ramAddrWidth(ramAddrWidth)) backend0
(
	.clock, .rstN, .memoryMode, .writeEnable, .wordAddress, .writeWord, .readWord,
	.fetchAddress, .instruction,
	.portAInput, .portBInput, .portCInput, .portDInput,
	.portEInput, .portFInput, .portGInput, .portHInput,
	.portAOutput, .portBOutput, .portCOutput, .portDOutput,
	.portEOutput, .portFOutput, .portGOutput, .portHOutput
);

endmodule : MemoryController

// File: tb/MemoryControllerTb.sv
`timescale 1ns/10ps

module MemoryControllerTb;

// One request vector from the data file
typedef struct packed
{
	logic isStore;
	logic [2:0] f3;
	logic [31:0] base;
	logic [31:0] imm;
	logic [31:0] data;
	logic [31:0] expLoad;
	logic expUnal;
	logic expBad;
} Vector;

logic clock;
logic rstN;
logic start;
MemoryTypes::MemoryOp op;
logic [2:0] funct3;
logic [31:0] rs1;
logic [31:0] immediate;
logic [31:0] rs2;
logic [31:0] fetchAddress;
logic [31:0] loadData;
logic busy;
logic done;
logic unalignedAccess;
logic badFunct3;
logic [31:0] instruction;
logic [31:0] portAOutput, portBOutput, portCOutput, portDOutput;
logic [31:0] portEOutput, portFOutput, portGOutput, portHOutput;

Vector vectors[$];
logic vectorsLoaded = 1'b0;
int seed = 32'hd00d;

MemoryController #(.ramAddrWidth(8)) dut0
(
	.clock, .rstN, .start, .op, .funct3, .rs1, .immediate, .rs2,
	.loadData, .busy, .done, .unalignedAccess, .badFunct3, .fetchAddress, .instruction,
	.portAInput(32'h11110000), .portBInput(32'h11110001), // Port n reads 11110000 + n
	.portCInput(32'h11110002), .portDInput(32'h11110003),
	.portEInput(32'h11110004), .portFInput(32'h11110005),
	.portGInput(32'h11110006), .portHInput(32'h11110007),
	.portAOutput, .portBOutput, .portCOutput, .portDOutput,
	.portEOutput, .portFOutput, .portGOutput, .portHOutput
);

initial clock = 1'b0;
always #50 clock = ~clock; // 100 ns period

task automatic checkValue(input string what, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected)
	begin
		$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
		$display("SOME TESTS FAILED");
		$fatal(1);
	end
endtask

// One access from start strobe to done with results sampled at the falling edge
task automatic runRequest(input logic isStore, input logic [2:0] f3, input logic [31:0] base,
	input logic [31:0] imm, input logic [31:0] data, output logic [31:0] result,
	output logic unal, output logic bad);
	int cycles;
	@(posedge clock);
	#1;
	op = isStore ? MemoryTypes::OP_STORE : MemoryTypes::OP_LOAD;
	funct3 = f3;
	rs1 = base;
	immediate = imm;
	rs2 = data;
	start = 1'b1;
	@(posedge clock); // Start sampled here
	#1 start = 1'b0;
	cycles = 0;
	do
	begin
		@(negedge clock);
		cycles++;
		if (cycles > 10)
		begin
			$display("No done from the controller within 10 cycles of start");
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end while (!done);
	checkValue("done latency in cycles", cycles, 32'd2); // Fixed latency
	checkValue("busy during done", {31'b0, busy}, 32'd1);
	result = loadData;
	unal = unalignedAccess;
	bad = badFunct3;
endtask

// Stops a hung run with a budget of four cycles per access
initial
begin
	wait (vectorsLoaded);
	#((vectors.size() + 20) * 4 * 100);
	$display("Watchdog timeout, the run did not finish in time");
	$display("SOME TESTS FAILED");
	$fatal(1);
end

initial
begin
	int fd;
	int n;
	string line;
	logic [31:0] fields [8];
	Vector v;
	logic [31:0] result;
	logic unal;
	logic bad;
	logic [31:0] randAddr [6];
	logic [31:0] randData [6];
	logic [31:0] shadow [256]; // Testbench copy of the RAM words

	rstN = 1'b0;
	start = 1'b0;
	op = MemoryTypes::OP_LOAD;
	funct3 = 3'b000;
	rs1 = 32'h0;
	immediate = 32'h0;
	rs2 = 32'h0;
	fetchAddress = 32'h0;

	fd = $fopen("tb/memory_testdata.txt", "r");
	if (fd == 0)
	begin
		$display("Could not open tb/memory_testdata.txt");
		$display("SOME TESTS FAILED");
		$fatal(1);
	end
	while ($fgets(line, fd) != 0)
	begin
		n = $sscanf(line, "%h %h %h %h %h %h %h %h", fields[0], fields[1], fields[2],
			fields[3], fields[4], fields[5], fields[6], fields[7]);
		if (n == 8)
		begin
			v = {fields[0][0], fields[1][2:0], fields[2], fields[3], fields[4],
				fields[5], fields[6][0], fields[7][0]};
			vectors.push_back(v);
		end
		else if (n > 0)
		begin
			$display("Malformed line in the test data file: %s", line);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end
	$fclose(fd);
	vectorsLoaded = 1'b1;

	repeat (5) @(posedge clock);
	#1 rstN = 1'b1;
	@(negedge clock);
	checkValue("busy after reset", {31'b0, busy}, 32'd0);
	checkValue("done after reset", {31'b0, done}, 32'd0);
	checkValue("port outputs after reset", portAOutput | portBOutput | portCOutput
		| portDOutput | portEOutput | portFOutput | portGOutput | portHOutput, 32'h0);

	// Directed vectors with loadData checked only for clean loads
	foreach (vectors[i])
	begin
		v = vectors[i];
		runRequest(v.isStore, v.f3, v.base, v.imm, v.data, result, unal, bad);
		checkValue($sformatf("vector %0d unalignedAccess", i), {31'b0, unal}, {31'b0, v.expUnal});
		checkValue($sformatf("vector %0d badFunct3", i), {31'b0, bad}, {31'b0, v.expBad});
		if (!v.isStore && !v.expUnal && !v.expBad)
			checkValue($sformatf("vector %0d loadData", i), result, v.expLoad);
	end

	// sw into port C window
	runRequest(1'b1, MemoryTypes::F3_WORD, 32'hFFFFFFE8, 32'h0, 32'hC0FFEE01, result, unal, bad);
	checkValue("port store flags", {30'b0, unal, bad}, 32'h0);
	@(negedge clock); // Past the write edge
	checkValue("portCOutput", portCOutput, 32'hC0FFEE01);
	checkValue("portBOutput", portBOutput, 32'h0); // Neighbours untouched
	checkValue("portDOutput", portDOutput, 32'h0);

	// Random word stores each read back on the fetch port
	for (int i = 0; i < 6; i++)
	begin
		randAddr[i] = $random(seed) & 32'h000003FC; // Inside the 256-word RAM
		randData[i] = $random(seed);
		runRequest(1'b1, MemoryTypes::F3_WORD, randAddr[i] - 32'd16, 32'd16, randData[i],
			result, unal, bad);
		checkValue("random store flags", {30'b0, unal, bad}, 32'h0);
		shadow[randAddr[i][9:2]] = randData[i];
		@(posedge clock); // Write edge
		#1 fetchAddress = randAddr[i];
		@(posedge clock);
		@(negedge clock);
		checkValue($sformatf("instruction at %h", randAddr[i]), instruction, randData[i]);
	end
	for (int i = 0; i < 6; i++)
	begin
		runRequest(1'b0, MemoryTypes::F3_WORD, randAddr[i], 32'h0, 32'h0, result, unal, bad);
		checkValue("random load flags", {30'b0, unal, bad}, 32'h0);
		checkValue($sformatf("lw at %h", randAddr[i]), result, shadow[randAddr[i][9:2]]);
	end

	$display("ALL TESTS PASSED");
	$finish;
end

endmodule : MemoryControllerTb

// File: tb/memory_testdata.txt
# op funct3 rs1 immediate rs2 loadData unalignedAccess badFunct3, all fields hex
# op 0 is a load and 1 a store, loadData is checked for loads without a fault
1 2 00000100 00000000 a1b2c3d4 00000000 0 0
0 2 000000f0 00000010 00000000 a1b2c3d4 0 0
1 0 00000100 00000001 ffffff5e 00000000 0 0
1 1 00000100 00000002 12348765 00000000 0 0
0 2 00000100 00000000 00000000 87655ed4 0 0
0 0 00000100 00000001 00000000 0000005e 0 0
0 0 00000100 00000003 00000000 ffffff87 0 0
0 4 00000100 00000003 00000000 00000087 0 0
0 1 00000100 00000002 00000000 ffff8765 0 0
0 5 00000100 00000002 00000000 00008765 0 0
0 1 00000100 00000000 00000000 00005ed4 0 0
0 0 00000110 fffffff0 00000000 ffffffd4 0 0
0 1 00000100 00000001 00000000 00000000 1 0
1 1 00000100 00000003 0000ffff 00000000 1 0
0 2 00000100 00000002 00000000 00000000 1 0
1 2 00000100 00000001 deadbeef 00000000 1 0
0 2 00000100 00000000 00000000 87655ed4 0 0
1 4 00000100 00000000 0badbad0 00000000 0 1
0 3 00000100 00000000 00000000 00000000 0 1
0 2 00000100 00000000 00000000 87655ed4 0 0
0 2 ffffffe0 00000010 00000000 11110004 0 0

// File: verilog.f
source/MemoryTypes.sv
source/MemoryAccessSequencer.sv
source/MemoryFaultDetector.sv
source/MemoryLoadFormatter.sv
source/MemoryStoreMerger.sv
source/MemoryBackend.sv
source/MemoryController.sv
tb/MemoryControllerTb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench, exit status is nonzero on failure
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module MemoryControllerTb -o MemoryControllerTb &&
./obj_dir/MemoryControllerTb || exit 1
